// File: compile.f
source/fm_pkg.sv
source/logsin_table.sv
source/exp_table.sv
source/operator_datapath.sv
source/wb_operator_regs.sv
source/fm_operator.sv
dv/fm_operator_checker.sv
dv/fm_operator_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := fm_operator_tb
FILELIST   := compile.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
RUN_FLAGS  := +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/fm_operator_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fm_operator_tb
        import fm_pkg::*;
();

        localparam int ACK_TIMEOUT = 16;
        localparam int IDLE_TIMEOUT = 40;
        localparam real PI_REF = 3.141592653589793;

        logic clk;
        logic rst_n;
        logic wb_cyc;
        logic wb_stb;
        logic wb_we;
        logic wb_adr;
        logic [31:0] wb_dat_w;
        logic [31:0] wb_dat_r;
        logic wb_ack;
        logic [15:0] lfsr_state;

        fm_operator i_dut (
                .clk      (clk),
                .rst_n    (rst_n),
                .wb_cyc   (wb_cyc),
                .wb_stb   (wb_stb),
                .wb_we    (wb_we),
                .wb_adr   (wb_adr),
                .wb_dat_w (wb_dat_w),
                .wb_dat_r (wb_dat_r),
                .wb_ack   (wb_ack)
        );

        initial clk = 1'b0;
        always #50 clk = ~clk;

        function automatic logic [15:0] lfsr_next(input logic [15:0] state);
                logic [15:0] next;
                next = state >> 1;
                if (state[0])
                        next = next ^ 16'hb400;
                return next;
        endfunction

        task automatic random_bits(input int count, output logic [31:0] bits);
                bits = '0;
                for (int i = 0; i < count; i++) begin
                        bits = {bits[30:0], lfsr_state[0]};
                        lfsr_state = lfsr_next(lfsr_state);
                end
        endtask

        function automatic int ref_logsin(input int idx);
                real s;
                s = $sin((real'(idx) + 0.5) * PI_REF / 512.0);
                return $rtoi(-$ln(s) / $ln(2.0) * 256.0 + 0.5);
        endfunction

        function automatic int ref_exp(input int idx);
                return $rtoi(($pow(2.0, real'(idx) / 256.0) - 1.0) * 1024.0 + 0.5);
        endfunction

        // Quarter-wave fold, log add with saturation, exponent, shift, sign.
        function automatic sample_t ref_sample(input phase_t phase, input att_t att);
                int idx;
                int sum;
                int mag;
                idx = int'(phase[7:0]);
                if (phase[8])
                        idx = 255 - idx;
                sum = ref_logsin(idx) + 8 * int'(att);
                if (sum > 8191)
                        sum = 8191;
                mag = (2 * (1024 + ref_exp(255 - sum % 256))) >> (sum / 256);
                if (phase[9])
                        mag = -mag;
                return sample_t'(mag);
        endfunction

        function automatic logic [31:0] operand_word(input phase_t phase, input att_t att);
                return {6'd0, att, 6'd0, phase};
        endfunction

        function automatic logic [31:0] result_word(input logic busy, input sample_t sample);
                logic signed [15:0] wide;
                wide = 16'(sample);
                return {busy, 15'd0, wide};
        endfunction

        task automatic stop_on_error();
                $display("TESTBENCH FAILED");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic check_word(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
                if (got !== expected) begin
                        $display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
                        stop_on_error();
                end
        endtask

        task automatic check_sample(input string name, input sample_t got,
                                    input sample_t expected);
                if (got !== expected) begin
                        $display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
                        stop_on_error();
                end
        endtask

        task automatic wait_for_ack();
                int cycles;
                cycles = 0;
                @(negedge clk);
                while (!wb_ack) begin
                        if (cycles == ACK_TIMEOUT) begin
                                $display("Timeout: the slave never acknowledged the bus cycle");
                                stop_on_error();
                        end
                        cycles++;
                        @(negedge clk);
                end
        endtask

        task automatic wb_write(input logic adr, input logic [31:0] data);
                @(negedge clk);
                wb_cyc = 1'b1;
                wb_stb = 1'b1;
                wb_we = 1'b1;
                wb_adr = adr;
                wb_dat_w = data;
                wait_for_ack();
                wb_cyc = 1'b0;
                wb_stb = 1'b0;
                wb_we = 1'b0;
        endtask

        task automatic wb_read(input logic adr, output logic [31:0] data);
                @(negedge clk);
                wb_cyc = 1'b1;
                wb_stb = 1'b1;
                wb_we = 1'b0;
                wb_adr = adr;
                wait_for_ack();
                data = wb_dat_r;
                wb_cyc = 1'b0;
                wb_stb = 1'b0;
        endtask

        task automatic wait_idle(output logic [31:0] status);
                int polls;
                polls = 0;
                wb_read(1'b1, status);
                while (status[31]) begin
                        if (polls == IDLE_TIMEOUT) begin
                                $display("Timeout: the busy flag never dropped");
                                stop_on_error();
                        end
                        polls++;
                        wb_read(1'b1, status);
                end
        endtask

        task automatic run_operand(input phase_t phase, input att_t att,
                                   input sample_t expected);
                logic [31:0] status;
                wb_write(1'b0, operand_word(phase, att));
                wait_idle(status);
                check_sample("wb_dat_r[12:0]", sample_t'(status[12:0]), expected);
                check_word("wb_dat_r", status, result_word(1'b0, expected));
        endtask

        task automatic test_reset_values();
                logic [31:0] data;
                wb_read(1'b1, data);
                check_word("wb_dat_r", data, result_word(1'b0, '0));
                wb_read(1'b0, data);
                check_word("wb_dat_r", data, 32'd0);
        endtask

        task automatic test_operand_readback();
                logic [31:0] data;
                logic [31:0] status;
                // Unused bits of the write word must not reach the register.
                wb_write(1'b0, operand_word(10'h2a5, 10'h13c) | 32'hfc00fc00);
                wb_read(1'b0, data);
                check_word("wb_dat_r", data, operand_word(10'h2a5, 10'h13c));
                wait_idle(status);
        endtask

        task automatic test_quadrants();
                if (ref_logsin(0) != 2137) begin
                        $display("The reference model gives a wrong log-sine value at index 0");
                        stop_on_error();
                end
                run_operand(10'd0, 10'd0, ref_sample(10'd0, 10'd0));
                run_operand(10'd255, 10'd0, ref_sample(10'd255, 10'd0));
                // The second quarter mirrors the first and the second half is negated.
                run_operand(10'd256, 10'd0, ref_sample(10'd255, 10'd0));
                run_operand(10'd511, 10'd0, ref_sample(10'd0, 10'd0));
                run_operand(10'd512, 10'd0, -ref_sample(10'd0, 10'd0));
                run_operand(10'd1023, 10'd0, -ref_sample(10'd0, 10'd0));
        endtask

        task automatic test_attenuation();
                sample_t peak;
                run_operand(10'd0, 10'h3ff, '0);
                run_operand(10'd256, 10'h300, '0);
                run_operand(10'd767, 10'h3ff, '0);
                // Peak of the wave has a log value of zero, so each octave halves it.
                peak = ref_sample(10'd255, 10'd0);
                for (int k = 1; k <= 5; k++) begin
                        run_operand(10'd255, att_t'(32 * k), peak >>> k);
                end
        endtask

        task automatic test_random();
                logic [31:0] bits;
                phase_t phase;
                att_t att;
                for (int n = 0; n < 200; n++) begin
                        random_bits(10, bits);
                        phase = bits[9:0];
                        random_bits(8, bits);
                        att = {2'b00, bits[7:0]};
                        run_operand(phase, att, ref_sample(phase, att));
                end
        endtask

        task automatic test_back_to_back();
                logic [31:0] status;
                logic [31:0] data;
                wb_write(1'b0, operand_word(10'h013, 10'h004));
                wb_write(1'b0, operand_word(10'h1c7, 10'h020));
                wb_write(1'b0, operand_word(10'h2f0, 10'h011));
                wb_write(1'b0, operand_word(10'h388, 10'h00a));
                wb_read(1'b1, status);
                if (!status[31]) begin
                        $display("The busy flag was low while samples were in flight");
                        stop_on_error();
                end
                wait_idle(status);
                check_word("wb_dat_r", status, result_word(1'b0, ref_sample(10'h388, 10'h00a)));
                wb_read(1'b0, data);
                check_word("wb_dat_r", data, operand_word(10'h388, 10'h00a));
        endtask

        always @(negedge clk) begin
                if (i_dut.i_regs.i_checker.error_count != 0) begin
                        $display("A bus or pipeline assertion failed");
                        stop_on_error();
                end
        end

        initial begin
                rst_n = 1'b0;
                wb_cyc = 1'b0;
                wb_stb = 1'b0;
                wb_we = 1'b0;
                wb_adr = 1'b0;
                wb_dat_w = 32'd0;
                lfsr_state = 16'd98;
                repeat (5) @(negedge clk);
                rst_n = 1'b1;
                test_reset_values();
                test_operand_readback();
                test_quadrants();
                test_attenuation();
                test_random();
                test_back_to_back();
                @(negedge clk);
                if (i_dut.i_regs.i_checker.error_count == 0) begin
                        $display("TESTBENCH PASSED");
                end else begin
                        $display("TESTBENCH FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: dv/fm_operator_checker.sv
`timescale 1ns/100ps
`default_nettype none

module fm_operator_checker (
        input wire logic clk,
        input wire logic rst_n,
        input wire logic wb_cyc,
        input wire logic wb_stb,
        input wire logic wb_ack,
        input wire logic in_valid,
        input wire logic out_valid,
        input wire logic busy
);

        int error_count = 0;

        ack_after_request: assert property (@(posedge clk) disable iff (!rst_n)
                $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
                else begin error_count++; $error("wb_ack rose without a request"); end

        ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
                wb_ack |=> !wb_ack)
                else begin error_count++; $error("wb_ack held for more than one cycle"); end

        // Fixed latency in both directions.
        pipeline_latency: assert property (@(posedge clk) disable iff (!rst_n)
                out_valid == $past(in_valid, 4))
                else begin error_count++; $error("out_valid does not trail in_valid by 4"); end

        quiet_in_reset: assert property (@(posedge clk)
                !rst_n |-> (!wb_ack && !busy))
                else begin error_count++; $error("wb_ack or busy high during reset"); end

endmodule

bind wb_operator_regs fm_operator_checker i_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_ack    (wb_ack),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .busy      (busy)
);

`default_nettype wire

// File: source/fm_operator.sv
`timescale 1ns/100ps
`default_nettype none

module fm_operator
        import fm_pkg::*;
(
        input  wire logic        clk,
        input  wire logic        rst_n,
        input  wire logic        wb_cyc,
        input  wire logic        wb_stb,
        input  wire logic        wb_we,
        input  wire logic        wb_adr,
        input  wire logic [31:0] wb_dat_w,
        output logic [31:0]      wb_dat_r,
        output logic             wb_ack
);

        logic in_valid;
        phase_t in_phase;
        att_t in_att;
        logic out_valid;
        sample_t out_sample;

        wb_operator_regs i_regs (
                .clk        (clk),
                .rst_n      (rst_n),
                .wb_cyc     (wb_cyc),
                .wb_stb     (wb_stb),
                .wb_we      (wb_we),
                .wb_adr     (wb_adr),
                .wb_dat_w   (wb_dat_w),
                .wb_dat_r   (wb_dat_r),
                .wb_ack     (wb_ack),
                .in_valid   (in_valid),
                .in_phase   (in_phase),
                .in_att     (in_att),
                .out_valid  (out_valid),
                .out_sample (out_sample)
        );

        operator_datapath i_datapath (
                .clk        (clk),
                .rst_n      (rst_n),
                .in_valid   (in_valid),
                .in_phase   (in_phase),
                .in_att     (in_att),
                .out_valid  (out_valid),
                .out_sample (out_sample)
        );

endmodule

`default_nettype wire

// File: source/wb_operator_regs.sv
`timescale 1ns/100ps
`default_nettype none

module wb_operator_regs
        import fm_pkg::*;
(
        input  wire logic        clk,
        input  wire logic        rst_n,
        input  wire logic        wb_cyc,
        input  wire logic        wb_stb,
        input  wire logic        wb_we,
        input  wire logic        wb_adr,
        input  wire logic [31:0] wb_dat_w,
        output logic [31:0]      wb_dat_r,
        output logic             wb_ack,
        output logic             in_valid,
        output phase_t           in_phase,
        output att_t             in_att,
        input  wire logic        out_valid,
        input  wire sample_t     out_sample
);

        logic request;
        logic launch;
        logic busy;
        logic [2:0] inflight;
        phase_t phase_r;
        att_t att_r;
        sample_t result_r;

        assign request = wb_cyc && wb_stb && !wb_ack;
        assign launch = request && wb_we && !wb_adr;
        assign busy = (inflight != 3'd0);

        assign in_phase = phase_r;
        assign in_att = att_r;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wb_ack <= 1'b0;
                        wb_dat_r <= 32'd0;
                        in_valid <= 1'b0;
                        phase_r <= '0;
                        att_r <= '0;
                end else begin
                        wb_ack <= request;
                        in_valid <= launch;
                        if (launch) begin
                                phase_r <= wb_dat_w[9:0];
                                att_r <= wb_dat_w[25:16];
                        end
                        if (request && !wb_we) begin
                                if (wb_adr)
                                        wb_dat_r <= {busy, 15'd0, {3{result_r[12]}}, result_r};
                                else
                                        wb_dat_r <= {6'd0, att_r, 6'd0, phase_r};
                        end
                end
        end

        // Counts samples between launch and completion; both may happen at once.
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        inflight <= 3'd0;
                        result_r <= '0;
                end else begin
                        inflight <= inflight + {2'b00, in_valid} - {2'b00, out_valid};
                        if (out_valid)
                                result_r <= out_sample;
                end
        end

endmodule

`default_nettype wire

// File: source/operator_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module operator_datapath
        import fm_pkg::*;
(
        input  wire logic clk,
        input  wire logic rst_n,
        input  wire logic in_valid,
        input  wire phase_t in_phase,
        input  wire att_t in_att,
        output logic      out_valid,
        output sample_t   out_sample
);

        logic [7:0] fold_idx;
        logsin_t logsin_val;
        exp_t exp_val;
        logic [13:0] sum_full;
        logic [11:0] magnitude;

        logic v1, v2, v3;
        logic sign1, sign2, sign3;
        att_t att1;
        log_t sum_r;
        logic [4:0] shift3;

        // Second quarter of each half wave is the mirror of the first.
        assign fold_idx = in_phase[8] ? ~in_phase[7:0] : in_phase[7:0];

        logsin_table i_logsin (
                .clk   (clk),
                .addr  (fold_idx),
                .value (logsin_val)
        );

        assign sum_full = {2'b00, logsin_val} + {1'b0, att1, 3'b000};

        // The table holds exp of the complement, so the fraction is inverted.
        exp_table i_exp (
                .clk   (clk),
                .addr  (~sum_r[7:0]),
                .value (exp_val)
        );

        assign magnitude = {1'b1, exp_val, 1'b0} >> shift3;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        v1 <= 1'b0;
                        v2 <= 1'b0;
                        v3 <= 1'b0;
                        out_valid <= 1'b0;
                end else begin
                        v1 <= in_valid;
                        v2 <= v1;
                        v3 <= v2;
                        out_valid <= v3;
                end
        end

        always_ff @(posedge clk) begin
                sign1 <= in_phase[9];
                att1 <= in_att;
                sign2 <= sign1;
                // Anything past 8191 is below the smallest output step anyway.
                sum_r <= sum_full[13] ? 13'h1fff : sum_full[12:0];
                sign3 <= sign2;
                shift3 <= sum_r[12:8];
                out_sample <= sign3 ? -sample_t'({1'b0, magnitude})
                                    : sample_t'({1'b0, magnitude});
        end

endmodule

`default_nettype wire

// File: source/exp_table.sv
`timescale 1ns/100ps
`default_nettype none

module exp_table
        import fm_pkg::*;
(
        input  wire logic    clk,
        input  wire logic [7:0] addr,
        output exp_t         value
);

        exp_t rom [0:255];
        logic [7:0] addr_r;

        initial begin
                for (int i = 0; i < 256; i++) begin
                        rom[i] = exp_value(i);
                end
        end

        always_ff @(posedge clk) begin
                addr_r <= addr;
        end

        always_comb begin
                value = rom[addr_r];
        end

endmodule

`default_nettype wire

// File: source/logsin_table.sv
`timescale 1ns/100ps
`default_nettype none

module logsin_table
        import fm_pkg::*;
(
        input  wire logic    clk,
        input  wire logic [7:0] addr,
        output logsin_t      value
);

        logsin_t rom [0:255];
        logic [7:0] addr_r;

        // Contents are computed once at elaboration.
        initial begin
                for (int i = 0; i < 256; i++) begin
                        rom[i] = logsin_value(i);
                end
        end

        // Registering the address lets the ROM map into block RAM.
        always_ff @(posedge clk) begin
                addr_r <= addr;
        end

        always_comb begin
                value = rom[addr_r];
        end

endmodule

`default_nettype wire

// File: source/fm_pkg.sv
`default_nettype none

package fm_pkg;

        typedef logic [9:0] phase_t;
        typedef logic [9:0] att_t;
        typedef logic [11:0] logsin_t;
        typedef logic [12:0] log_t;
        typedef logic [9:0] exp_t;
        typedef logic signed [12:0] sample_t;

        localparam real PI = 3.14159265358979323846;

        // Attenuation of a quarter-wave sample, in 1/256 octave steps.
        function automatic logsin_t logsin_value(input int idx);
                real angle;
                real level;
                angle = (real'(idx) + 0.5) * PI / 512.0;
                level = -($ln($sin(angle)) / $ln(2.0)) * 256.0;
                return logsin_t'($rtoi(level + 0.5));
        endfunction

        // Fractional part of the mantissa for one 1/256 octave step.
        function automatic exp_t exp_value(input int idx);
                real mant;
                mant = ($pow(2.0, real'(idx) / 256.0) - 1.0) * 1024.0;
                return exp_t'($rtoi(mant + 0.5));
        endfunction

endpackage

`default_nettype wire
